//--- execute_golden.txt
# class op waddr rdata1 rdata2 imm pc npc size signed byte_enable mem_wait mem_rdata
# clear_after exp_wren exp_wdata, all hex, one test per line
0 0 01 00000005 00000007 00000000 00000000 00000004 0 0 0 00 00000000 00 1 0000000c
0 1 02 00000003 00000005 00000000 00000000 00000004 0 0 0 00 00000000 00 1 fffffffe
0 7 03 80000010 00000004 00000000 00000000 00000004 0 0 0 00 00000000 00 1 f8000001
0 4 04 fffffff0 00000001 00000000 00000000 00000004 0 0 0 00 00000000 00 1 00000000
0 a 05 00000000 deadbeef 12345000 00000000 00000004 0 0 0 00 00000000 00 1 12345000
0 b 06 00000000 deadbeef 00000800 00001000 00001004 0 0 0 00 00000000 00 1 00001800
0 c 07 00000000 00000000 00000000 00000100 00000104 0 0 0 00 00000000 00 1 00000104
0 0 00 00000001 00000001 00000000 00000000 00000004 0 0 0 00 00000000 00 0 00000002
1 0 08 00000003 fffffffe 00000000 00000000 00000004 0 0 0 00 00000000 00 1 fffffffa
1 1 09 80000000 80000000 00000000 00000000 00000004 0 0 0 00 00000000 00 1 40000000
1 2 0a ffffffff ffffffff 00000000 00000000 00000004 0 0 0 00 00000000 00 1 ffffffff
1 3 0b ffffffff ffffffff 00000000 00000000 00000004 0 0 0 00 00000000 00 1 fffffffe
1 8 0c fffffff9 00000002 00000000 00000000 00000004 0 0 0 00 00000000 00 1 fffffffd
1 9 0d 00000064 00000007 00000000 00000000 00000004 0 0 0 00 00000000 00 1 0000000e
1 a 0e fffffff9 00000002 00000000 00000000 00000004 0 0 0 00 00000000 00 1 ffffffff
1 b 0f 00000064 00000007 00000000 00000000 00000004 0 0 0 00 00000000 00 1 00000002
1 8 10 00000011 00000000 00000000 00000000 00000004 0 0 0 00 00000000 00 1 ffffffff
1 8 11 80000000 ffffffff 00000000 00000000 00000004 0 0 0 00 00000000 00 1 80000000
1 a 12 80000000 ffffffff 00000000 00000000 00000004 0 0 0 00 00000000 00 1 00000000
1 8 13 00001000 00000003 00000000 00000000 00000004 0 0 0 00 00000000 05 0 00000000
2 0 14 00000000 00000000 00000000 00000000 00000004 0 1 4 03 11a23344 00 1 ffffffa2
2 0 15 00000000 00000000 00000000 00000000 00000004 1 0 c 00 8001beef 00 1 00008001
2 0 16 00000000 00000000 00000000 00000000 00000004 2 0 f 02 cafef00d 00 1 cafef00d
3 0 17 00000000 00000000 00000000 00000000 00000004 2 0 f 02 00000000 00 0 00000000
4 0 18 00000000 00000000 00000000 00000000 00000004 2 0 0 01 00000000 00 0 00000000

//--- files.f
exec_op_pkg.sv
exec_mem_pkg.sv
int_alu.sv
int_mul.sv
int_div.sv
load_align.sv
execute_stage.sv
execute_top.sv
execute_sva.sv
execute_tb.sv

//--- Bender.yml
package:
  name: execute_stage

sources:
  - exec_op_pkg.sv
  - exec_mem_pkg.sv
  - int_alu.sv
  - int_mul.sv
  - int_div.sv
  - load_align.sv
  - execute_stage.sv
  - execute_top.sv
  - target: test
    files:
      - execute_sva.sv
      - execute_tb.sv

//--- execute_tb.sv
module execute_tb;

  import exec_op_pkg::*;
  import exec_mem_pkg::*;

  localparam int xlen         = 32;
  localparam int div_steps    = xlen;
  localparam int max_tests    = 64;
  localparam int reset_cycles = 16;

  logic                clock;
  logic                reset;
  logic                issue_valid;
  unit_class_e         unit_class;
  op_word_u            op_word;
  logic [xlen-1:0]     rdata1;
  logic [xlen-1:0]     rdata2;
  logic [xlen-1:0]     imm;
  logic [xlen-1:0]     pc;
  logic [xlen-1:0]     npc;
  logic [4:0]          waddr;
  load_size_e          load_size;
  logic                load_signed;
  logic [be_width-1:0] byte_enable;
  logic                mem_ready;
  logic [xlen-1:0]     mem_rdata;
  logic                clear;
  logic                stall;
  logic                reg_wren;
  logic [4:0]          reg_waddr;
  logic [xlen-1:0]     reg_wdata;

  // one row of the golden file per test, sixteen hex columns.
  logic [31:0] golden [max_tests][16];
  int          test_count;
  int          test_errors;
  int          passed;
  int          failed;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  logic [31:0] lfsr;

  execute_top #(
    .xlen      (xlen),
    .div_steps (div_steps)
  ) execute_top_inst (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (issue_valid),
    .unit_class  (unit_class),
    .op_word     (op_word),
    .rdata1      (rdata1),
    .rdata2      (rdata2),
    .imm         (imm),
    .pc          (pc),
    .npc         (npc),
    .waddr       (waddr),
    .load_size   (load_size),
    .load_signed (load_signed),
    .byte_enable (byte_enable),
    .mem_ready   (mem_ready),
    .mem_rdata   (mem_rdata),
    .clear       (clear),
    .stall       (stall),
    .reg_wren    (reg_wren),
    .reg_waddr   (reg_waddr),
    .reg_wdata   (reg_wdata)
  );

  always #10 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles, the run was stopped", cycle_count);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // helpers

  // fibonacci form with taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("FAIL time %0t %s expected %h actual %h", $time, name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic load_golden(output bit ok);
    int          fd;
    int          code;
    string       line;
    logic [31:0] col [16];
    ok = 1'b0;
    test_count  = 0;
    cycle_limit = reset_cycles + 2;
    fd = $fopen("execute_golden.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line[0] != "#" && test_count < max_tests) begin
          code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                         col[8], col[9], col[10], col[11], col[12], col[13], col[14],
                         col[15]);
          if (code == 16) begin
            golden[test_count] = col;
            cycle_limit += 40 + col[11] + 3;
            test_count++;
          end
        end
      end
      $fclose(fd);
      ok = (test_count > 0);
    end
  endtask

  task automatic run_test(input int idx);
    logic [31:0] row [16];
    int          stalled;
    int          waited;
    int          exp_stall;
    bit          holding;
    unit_class_e cls;
    row = golden[idx];
    cls = unit_class_e'(row[0][2:0]);
    test_errors = 0;
    stalled = 0;
    waited = 0;

    // a divide stalls for its steps plus one, or until one cycle after clear.
    if (cls == uc_muldiv && row[1][3]) begin
      exp_stall = (row[13] != 0) ? row[13] + 1 : div_steps + 1;
    end else if (cls inside {uc_load, uc_store, uc_fence}) begin
      exp_stall = row[11];
    end else begin
      exp_stall = 0;
    end

    @(posedge clock);
    issue_valid <= 1'b1;
    unit_class  <= cls;
    op_word     <= op_word_u'(row[1][3:0]);
    waddr       <= row[2][4:0];
    rdata1      <= row[3];
    rdata2      <= row[4];
    imm         <= row[5];
    pc          <= row[6];
    npc         <= row[7];
    load_size   <= load_size_e'(row[8][1:0]);
    load_signed <= row[9][0];
    byte_enable <= row[10][be_width-1:0];
    mem_ready   <= (row[11] == 0);
    mem_rdata   <= row[12];

    @(negedge clock);
    while (stall) @(negedge clock);
    @(posedge clock);
    issue_valid <= 1'b0;

    holding = 1'b1;
    while (holding) begin
      @(negedge clock);
      if (!stall) begin
        holding = 1'b0;
      end else begin
        stalled++;
        compare_value("reg_wren", 0, reg_wren);
        @(posedge clock);
        waited++;
        if (waited == row[11]) begin
          mem_ready <= 1'b1;
        end
        if (clear) begin
          clear <= 1'b0;
        end else if (row[13] != 0 && stalled == row[13]) begin
          clear <= 1'b1;
        end
      end
    end

    compare_value("stall_cycles", exp_stall, stalled);
    compare_value("reg_wren", row[14], reg_wren);
    if (row[14][0]) begin
      compare_value("reg_waddr", row[2], reg_waddr);
      compare_value("reg_wdata", row[15], reg_wdata);
    end

    if (test_errors == 0) begin
      passed++;
      $display("test %0d class %0d op %h passed, %0d stall cycles",
               idx, row[0], row[1][3:0], stalled);
    end else begin
      failed++;
      $display("test %0d class %0d op %h failed with %0d errors",
               idx, row[0], row[1][3:0], test_errors);
    end
  endtask

  // ----------------------------------------------------------------------
  // main sequence

  initial begin
    bit         golden_ok;
    logic [1:0] idle;
    clock       = 1'b0;
    reset       = 1'b0;
    issue_valid = 1'b0;
    unit_class  = uc_alu;
    op_word     = '0;
    rdata1      = '0;
    rdata2      = '0;
    imm         = '0;
    pc          = '0;
    npc         = '0;
    waddr       = '0;
    load_size   = size_word;
    load_signed = 1'b0;
    byte_enable = '0;
    mem_ready   = 1'b0;
    mem_rdata   = '0;
    clear       = 1'b0;
    passed      = 0;
    failed      = 0;
    lfsr        = 32'hb53f96fc;
    load_golden(golden_ok);
    if (!golden_ok) begin
      $display("could not read any test from execute_golden.txt");
      $display("TEST RESULT: FAIL");
      $finish;
    end else begin
      repeat (reset_cycles) @(posedge clock);
      reset <= 1'b1;
      for (int i = 0; i < test_count; i++) begin
        run_test(i);
        lfsr = lfsr_step(lfsr);
        idle[0] = lfsr[0];
        lfsr = lfsr_step(lfsr);
        idle[1] = lfsr[0];
        repeat (idle) @(posedge clock);
      end
      $display("tests %0d, passed %0d, failed %0d", test_count, passed, failed);
      if (failed == 0) begin
        $display("TEST RESULT: PASS");
      end else begin
        $display("TEST RESULT: FAIL");
      end
      $finish;
    end
  end

endmodule

//--- execute_sva.sv
module execute_sva (
  input logic clock,
  input logic reset,
  input logic stall,
  input logic writes_reg,
  input logic reg_wren,
  input logic div_start,
  input logic clear
);

  // a stalled instruction that writes keeps its write pending while the stall
  // lasts, and the write appears in the cycle the stall ends.
  write_outside_stall: assert property (
    @(posedge clock) disable iff (reset == 0)
      stall && writes_reg && !clear |=> reg_wren != stall
  ) else $error("the write of a stalled instruction is early or missing");

  start_single_cycle: assert property (
    @(posedge clock) disable iff (reset == 0) div_start |=> !div_start
  ) else $error("div_start stays high for more than one cycle");

  // clear empties the instruction register, so nothing is left to hold the stall.
  clear_releases_stall: assert property (
    @(posedge clock) disable iff (reset == 0) clear |=> !stall
  ) else $error("stall is still high in the cycle after clear");

endmodule

bind execute_stage execute_sva execute_sva_inst (
  .clock      (clock),
  .reset      (reset),
  .stall      (stall),
  .writes_reg (writes_reg),
  .reg_wren   (reg_wren),
  .div_start  (div_start),
  .clear      (clear)
);

//--- execute_top.sv
module execute_top #(
  parameter int xlen      = 32,
  parameter int div_steps = xlen
) (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              issue_valid,
  input  exec_op_pkg::unit_class_e          unit_class,
  input  exec_op_pkg::op_word_u             op_word,
  input  logic [xlen-1:0]                   rdata1,
  input  logic [xlen-1:0]                   rdata2,
  input  logic [xlen-1:0]                   imm,
  input  logic [xlen-1:0]                   pc,
  input  logic [xlen-1:0]                   npc,
  input  logic [4:0]                        waddr,
  input  exec_mem_pkg::load_size_e          load_size,
  input  logic                              load_signed,
  input  logic [exec_mem_pkg::be_width-1:0] byte_enable,
  input  logic                              mem_ready,
  input  logic [xlen-1:0]                   mem_rdata,
  input  logic                              clear,
  output logic                              stall,
  output logic                              reg_wren,
  output logic [4:0]                        reg_waddr,
  output logic [xlen-1:0]                   reg_wdata
);

  import exec_op_pkg::*;
  import exec_mem_pkg::*;

  alu_op_e               alu_op;
  md_op_e                md_op;
  logic [xlen-1:0]       alu_a;
  logic [xlen-1:0]       alu_b;
  logic [xlen-1:0]       alu_pc;
  logic [xlen-1:0]       alu_npc;
  logic [xlen-1:0]       md_a;
  logic [xlen-1:0]       md_b;
  logic                  div_start;
  logic                  div_kill;
  logic                  div_done;
  logic [xlen-1:0]       alu_result;
  logic [xlen-1:0]       mul_result;
  logic [xlen-1:0]       div_result;
  logic [xlen-1:0]       load_data;
  load_size_e            load_size_q;
  logic                  load_signed_q;
  logic [be_width-1:0]   byte_enable_q;

  execute_stage #(
    .xlen(xlen)
  ) execute_stage_inst (
    .clock         (clock),
    .reset         (reset),
    .issue_valid   (issue_valid),
    .unit_class    (unit_class),
    .op_word       (op_word),
    .rdata1        (rdata1),
    .rdata2        (rdata2),
    .imm           (imm),
    .pc            (pc),
    .npc           (npc),
    .waddr         (waddr),
    .load_size     (load_size),
    .load_signed   (load_signed),
    .byte_enable   (byte_enable),
    .mem_ready     (mem_ready),
    .clear         (clear),
    .alu_op        (alu_op),
    .alu_a         (alu_a),
    .alu_b         (alu_b),
    .alu_pc        (alu_pc),
    .alu_npc       (alu_npc),
    .md_op         (md_op),
    .md_a          (md_a),
    .md_b          (md_b),
    .div_start     (div_start),
    .div_kill      (div_kill),
    .alu_result    (alu_result),
    .mul_result    (mul_result),
    .div_done      (div_done),
    .div_result    (div_result),
    .load_data     (load_data),
    .load_size_q   (load_size_q),
    .load_signed_q (load_signed_q),
    .byte_enable_q (byte_enable_q),
    .stall         (stall),
    .reg_wren      (reg_wren),
    .reg_waddr     (reg_waddr),
    .reg_wdata     (reg_wdata)
  );

  int_alu #(
    .xlen(xlen)
  ) int_alu_inst (
    .op     (alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .pc     (alu_pc),
    .npc    (alu_npc),
    .result (alu_result)
  );

  int_mul #(
    .xlen(xlen)
  ) int_mul_inst (
    .op     (md_op),
    .a      (md_a),
    .b      (md_b),
    .result (mul_result)
  );

  int_div #(
    .xlen      (xlen),
    .div_steps (div_steps)
  ) int_div_inst (
    .clock  (clock),
    .reset  (reset),
    .start  (div_start),
    .op     (md_op),
    .kill   (div_kill),
    .a      (md_a),
    .b      (md_b),
    .done   (div_done),
    .result (div_result)
  );

  load_align #(
    .xlen(xlen)
  ) load_align_inst (
    .mem_rdata   (mem_rdata),
    .byte_enable (byte_enable_q),
    .size        (load_size_q),
    .sign        (load_signed_q),
    .data        (load_data)
  );

endmodule

//--- execute_stage.sv
module execute_stage #(
  parameter int xlen = 32
) (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              issue_valid,
  input  exec_op_pkg::unit_class_e          unit_class,
  input  exec_op_pkg::op_word_u             op_word,
  input  logic [xlen-1:0]                   rdata1,
  input  logic [xlen-1:0]                   rdata2,
  input  logic [xlen-1:0]                   imm,
  input  logic [xlen-1:0]                   pc,
  input  logic [xlen-1:0]                   npc,
  input  logic [4:0]                        waddr,
  input  exec_mem_pkg::load_size_e          load_size,
  input  logic                              load_signed,
  input  logic [exec_mem_pkg::be_width-1:0] byte_enable,
  input  logic                              mem_ready,
  input  logic                              clear,
  output exec_op_pkg::alu_op_e              alu_op,
  output logic [xlen-1:0]                   alu_a,
  output logic [xlen-1:0]                   alu_b,
  output logic [xlen-1:0]                   alu_pc,
  output logic [xlen-1:0]                   alu_npc,
  output exec_op_pkg::md_op_e               md_op,
  output logic [xlen-1:0]                   md_a,
  output logic [xlen-1:0]                   md_b,
  output logic                              div_start,
  output logic                              div_kill,
  input  logic [xlen-1:0]                   alu_result,
  input  logic [xlen-1:0]                   mul_result,
  input  logic                              div_done,
  input  logic [xlen-1:0]                   div_result,
  input  logic [xlen-1:0]                   load_data,
  output exec_mem_pkg::load_size_e          load_size_q,
  output logic                              load_signed_q,
  output logic [exec_mem_pkg::be_width-1:0] byte_enable_q,
  output logic                              stall,
  output logic                              reg_wren,
  output logic [4:0]                        reg_waddr,
  output logic [xlen-1:0]                   reg_wdata
);

  import exec_op_pkg::*;

  logic            valid_q;
  logic            first_q;
  unit_class_e     class_q;
  op_word_u        op_q;
  logic [xlen-1:0] rdata1_q;
  logic [xlen-1:0] rdata2_q;
  logic [xlen-1:0] imm_q;
  logic [xlen-1:0] pc_q;
  logic [xlen-1:0] npc_q;
  logic [4:0]      waddr_q;
  logic            is_alu;
  logic            is_muldiv;
  logic            is_div;
  logic            is_load;
  logic            is_mem;
  logic            writes_reg;

  // -------------------------------------------------------------------
  // instruction register

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      valid_q <= 1'b0;
      first_q <= 1'b0;
    end else if (clear) begin
      valid_q <= 1'b0;
      first_q <= 1'b0;
    end else if (!stall) begin
      valid_q <= issue_valid;
      first_q <= issue_valid;
    end else begin
      first_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) begin
      class_q       <= unit_class;
      op_q          <= op_word;
      rdata1_q      <= rdata1;
      rdata2_q      <= rdata2;
      imm_q         <= imm;
      pc_q          <= pc;
      npc_q         <= npc;
      waddr_q       <= waddr;
      load_size_q   <= load_size;
      load_signed_q <= load_signed;
      byte_enable_q <= byte_enable;
    end
  end

  // -------------------------------------------------------------------
  // decode and unit operands

  always_comb begin
    is_alu    = valid_q && (class_q == uc_alu);
    is_muldiv = valid_q && (class_q == uc_muldiv);
    is_load   = valid_q && (class_q == uc_load);
    is_mem    = valid_q && (class_q inside {uc_load, uc_store, uc_fence});
    // the op word means a divide only inside the multiply/divide class.
    is_div    = is_muldiv && (op_q.md inside {md_div, md_divu, md_rem, md_remu});
  end

  assign alu_op  = op_q.alu;
  assign alu_a   = rdata1_q;
  // register-immediate forms arrive with the immediate already in rdata2.
  assign alu_b   = (op_q.alu inside {alu_lui, alu_auipc}) ? imm_q : rdata2_q;
  assign alu_pc  = pc_q;
  assign alu_npc = npc_q;

  assign md_op = op_q.md;
  assign md_a  = rdata1_q;
  assign md_b  = rdata2_q;

  assign div_start = is_div && first_q;
  assign div_kill  = clear;

  // -------------------------------------------------------------------
  // stall and register write

  assign stall = (is_div && !div_done) || (is_mem && !mem_ready);

  assign writes_reg = (is_alu || is_muldiv || is_load) && (waddr_q != 5'd0);
  assign reg_wren   = writes_reg && !stall;
  assign reg_waddr  = waddr_q;

  always_comb begin
    case (class_q)
      uc_muldiv: reg_wdata = is_div ? div_result : mul_result;
      uc_load:   reg_wdata = load_data;
      default:   reg_wdata = alu_result;
    endcase
  end

endmodule

//--- load_align.sv
module load_align #(
  parameter int xlen = 32
) (
  input  logic [xlen-1:0]                   mem_rdata,
  input  logic [exec_mem_pkg::be_width-1:0] byte_enable,
  input  exec_mem_pkg::load_size_e          size,
  input  logic                              sign,
  output logic [xlen-1:0]                   data
);

  import exec_mem_pkg::*;

  localparam int lane_width = $clog2(be_width);

  logic [lane_width-1:0] lane;
  logic [xlen-1:0]       shifted;
  logic                  msb;
  logic                  fill;

  // the lowest enabled lane holds the addressed byte.
  always_comb begin
    lane = '0;
    for (int i = be_width - 1; i >= 0; i--) begin
      if (byte_enable[i]) begin
        lane = lane_width'(i);
      end
    end
  end

  assign shifted = mem_rdata >> {lane, 3'b000};

  always_comb begin
    case (size)
      size_byte: msb = shifted[7];
      size_half: msb = shifted[15];
      default:   msb = shifted[xlen-1];
    endcase
    fill = 1'b0;
    case (load_ext_e'(sign))
      ext_zero: fill = 1'b0;
      ext_sign: fill = msb;
    endcase
    case (size)
      size_byte: data = {{(xlen-8){fill}}, shifted[7:0]};
      size_half: data = {{(xlen-16){fill}}, shifted[15:0]};
      default:   data = mem_rdata;
    endcase
  end

endmodule

//--- int_div.sv
module int_div #(
  parameter int xlen      = 32,
  parameter int div_steps = 32
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                start,
  input  exec_op_pkg::md_op_e op,
  input  logic                kill,
  input  logic [xlen-1:0]     a,
  input  logic [xlen-1:0]     b,
  output logic                done,
  output logic [xlen-1:0]     result
);

  import exec_op_pkg::*;

  localparam int count_width = $clog2(div_steps + 1);

  logic                   busy;
  logic [count_width-1:0] count;
  logic [xlen-1:0]        quo;
  logic [xlen-1:0]        rem;
  logic [xlen-1:0]        dvs;
  logic                   neg_quo;
  logic                   neg_rem;
  logic                   want_rem;
  logic                   op_signed;
  logic                   a_neg;
  logic                   b_neg;
  logic [xlen:0]          rem_shift;
  logic [xlen:0]          diff;

  assign op_signed = (op == md_div) || (op == md_rem);
  assign a_neg     = op_signed & a[xlen-1];
  assign b_neg     = op_signed & b[xlen-1];

  assign rem_shift = {rem, quo[xlen-1]};
  assign diff      = rem_shift - {1'b0, dvs};

  // -------------------------------------------------------------------
  // step control

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      busy  <= 1'b0;
      done  <= 1'b0;
      count <= '0;
    end else if (kill) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else if (start) begin
      busy  <= 1'b1;
      done  <= 1'b0;
      count <= '0;
    end else if (busy) begin
      count <= count + 1'b1;
      if (count == div_steps - 1) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end else begin
      done <= 1'b0;
    end
  end

  // -------------------------------------------------------------------
  // restoring shift-subtract on magnitudes

  always_ff @(posedge clock) begin
    if (start) begin
      quo      <= a_neg ? -a : a;
      rem      <= '0;
      dvs      <= b_neg ? -b : b;
      // a zero divisor leaves an all-ones quotient, which must stay positive.
      neg_quo  <= (a_neg ^ b_neg) & (|b);
      neg_rem  <= a_neg;
      want_rem <= (op == md_rem) || (op == md_remu);
    end else if (busy) begin
      if (!diff[xlen]) begin
        rem <= diff[xlen-1:0];
        quo <= {quo[xlen-2:0], 1'b1};
      end else begin
        rem <= rem_shift[xlen-1:0];
        quo <= {quo[xlen-2:0], 1'b0};
      end
    end
  end

  // signed overflow needs no special case, the magnitude path already
  // yields the dividend and a zero remainder.
  assign result = want_rem ? (neg_rem ? -rem : rem) : (neg_quo ? -quo : quo);

endmodule

//--- int_mul.sv
module int_mul #(
  parameter int xlen = 32
) (
  input  exec_op_pkg::md_op_e op,
  input  logic [xlen-1:0]     a,
  input  logic [xlen-1:0]     b,
  output logic [xlen-1:0]     result
);

  import exec_op_pkg::*;

  logic                     a_signed;
  logic                     b_signed;
  logic [xlen:0]            a_ext;
  logic [xlen:0]            b_ext;
  logic signed [2*xlen+1:0] product;

  // one extra bit per operand lets a single signed multiply cover all forms.
  assign a_signed = (op == md_mulh) || (op == md_mulhsu);
  assign b_signed = (op == md_mulh);

  assign a_ext = {a_signed & a[xlen-1], a};
  assign b_ext = {b_signed & b[xlen-1], b};

  assign product = $signed(a_ext) * $signed(b_ext);

  assign result = (op == md_mul) ? product[xlen-1:0] : product[2*xlen-1:xlen];

endmodule

//--- int_alu.sv
module int_alu #(
  parameter int xlen = 32
) (
  input  exec_op_pkg::alu_op_e op,
  input  logic [xlen-1:0]      a,
  input  logic [xlen-1:0]      b,
  input  logic [xlen-1:0]      pc,
  input  logic [xlen-1:0]      npc,
  output logic [xlen-1:0]      result
);

  import exec_op_pkg::*;

  localparam int shamt_width = $clog2(xlen);

  logic [shamt_width-1:0] shamt;

  assign shamt = b[shamt_width-1:0];

  always_comb begin
    case (op)
      alu_add:   result = a + b;
      alu_sub:   result = a - b;
      alu_sll:   result = a << shamt;
      alu_slt:   result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      alu_sltu:  result = {{(xlen-1){1'b0}}, a < b};
      alu_xor:   result = a ^ b;
      alu_srl:   result = a >> shamt;
      alu_sra:   result = $signed(a) >>> shamt;
      alu_or:    result = a | b;
      alu_and:   result = a & b;
      // lui arrives with the immediate already shifted into place.
      alu_lui:   result = b;
      alu_auipc: result = pc + b;
      // jal and jalr write the address of the following instruction.
      alu_link:  result = npc;
      default:   result = '0;
    endcase
  end

endmodule

//--- exec_mem_pkg.sv
package exec_mem_pkg;

  // one enable per byte lane of the data memory word.
  localparam int unsigned be_width = 4;

  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } load_size_e;

  // how a narrow load is extended to the full register.
  typedef enum logic {
    ext_zero = 1'b0,
    ext_sign = 1'b1
  } load_ext_e;

endpackage

//--- exec_op_pkg.sv
package exec_op_pkg;

  // the unit that executes the instruction held in the stage.
  typedef enum logic [2:0] {
    uc_alu    = 3'd0,
    uc_muldiv = 3'd1,
    uc_load   = 3'd2,
    uc_store  = 3'd3,
    uc_fence  = 3'd4
  } unit_class_e;

  typedef enum logic [3:0] {
    alu_add   = 4'd0,
    alu_sub   = 4'd1,
    alu_sll   = 4'd2,
    alu_slt   = 4'd3,
    alu_sltu  = 4'd4,
    alu_xor   = 4'd5,
    alu_srl   = 4'd6,
    alu_sra   = 4'd7,
    alu_or    = 4'd8,
    alu_and   = 4'd9,
    alu_lui   = 4'd10,
    alu_auipc = 4'd11,
    alu_link  = 4'd12
  } alu_op_e;

  // the top bit selects the divider.
  typedef enum logic [3:0] {
    md_mul    = 4'b0000,
    md_mulh   = 4'b0001,
    md_mulhsu = 4'b0010,
    md_mulhu  = 4'b0011,
    md_div    = 4'b1000,
    md_divu   = 4'b1001,
    md_rem    = 4'b1010,
    md_remu   = 4'b1011
  } md_op_e;

  // one operation word, read according to the unit class.
  typedef union packed {
    alu_op_e alu;
    md_op_e  md;
  } op_word_u;

endpackage
